// ==== verilog/adapter_mem_pkg.sv ====
// Adapter memory package
// Internal request, write data and response formats shared by the
// source stages, the arbiter, the bridge and the response demux.
// Also holds the source port numbering and instruction-cache sizes.

`default_nettype none

package adapter_mem_pkg;

  typedef logic [39:0]  mem_addr_t;
  typedef logic [1:0]   mem_id_t;
  typedef logic [2:0]   mem_size_t;
  typedef logic [63:0]  mem_wdata_t;
  typedef logic [127:0] mem_rdata_t;
  typedef logic [7:0]   inv_idx_t;

  // Port 0 is the I$, port 1 the D$ read, port 2 the uncached write
  typedef logic [1:0] port_id_t;
  localparam int PORT_CNT = 3;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } mem_cmd_e;

  typedef struct packed {
    mem_addr_t addr;
    mem_size_t size;
    mem_id_t   id;
    mem_cmd_e  cmd;
    logic      cacheable;
  } mem_req_t;

  typedef struct packed {
    mem_rdata_t data;
    mem_id_t    id;
    logic       error;
    logic       inv;
    inv_idx_t   inv_idx;
  } mem_resp_t;

  typedef struct packed {
    mem_addr_t paddr;
    logic      nc;
    mem_id_t   tid;
  } icache_miss_t;

  // Log2 of the access bytes for I$ fills
  localparam int ICACHE_WORD_SIZE = 3;
  localparam int ICACHE_LINE_SIZE = 4;

endpackage

`default_nettype wire

// ==== verilog/l15_pkg.sv ====
// L1.5 package
// Native request and return formats of the L1.5 cache, with their
// type encodings, and the return format seen by the instruction cache.

`default_nettype none

package l15_pkg;

  // Request types, OpenPiton encoding
  typedef enum logic [4:0] {
    LOAD  = 5'b00000,
    STORE = 5'b00001,
    IFILL = 5'b10000
  } l15_rqtype_e;

  // Return types
  typedef enum logic [3:0] {
    LOAD_RET  = 4'b0000,
    IFILL_RET = 4'b0001,
    INV       = 4'b0011,
    ST_ACK    = 4'b0100
  } l15_rtype_e;

  typedef struct packed {
    logic                       val;
    l15_rqtype_e                rqtype;
    logic                       nc;
    adapter_mem_pkg::mem_size_t size;
    adapter_mem_pkg::mem_id_t   threadid;
    adapter_mem_pkg::mem_addr_t address;
    adapter_mem_pkg::mem_wdata_t data;
  } l15_req_t;

  typedef struct packed {
    logic                        val;
    logic                        header_ack;
    l15_rtype_e                  rtype;
    adapter_mem_pkg::mem_id_t    threadid;
    adapter_mem_pkg::mem_rdata_t data;
    adapter_mem_pkg::inv_idx_t   inv_index;
  } l15_rtrn_t;

  typedef struct packed {
    logic                        is_inv;
    adapter_mem_pkg::mem_rdata_t data;
    adapter_mem_pkg::inv_idx_t   inv_index;
    adapter_mem_pkg::mem_id_t    tid;
  } icache_rtrn_t;

endpackage

`default_nettype wire

// ==== verilog/req_slot.sv ====
// Request slot
// One-entry holding register with write-ok and read-ok flags.
// Accepts a new entry when empty or when read in the same cycle.

`default_nettype none

module req_slot #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire logic     w_i,
  output logic          wok_o,
  input  wire payload_t wdata_i,
  input  wire logic     r_i,
  output logic          rok_o,
  output payload_t      rdata_o
);

  logic     full_q;
  payload_t data_q;

  // Free when empty or drained this cycle
  assign wok_o = ~full_q | r_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (w_i && wok_o) begin
      full_q <= 1'b1;
    end else if (r_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i && wok_o) begin
      data_q <= wdata_i;
    end
  end

  assign rok_o   = full_q;
  assign rdata_o = data_q;

endmodule

`default_nettype wire

// ==== verilog/icache_miss_adapter.sv ====
// Instruction cache miss adapter
// Turns I$ fill requests into memory read requests held in a slot,
// so a miss withdrawn by the I$ is still issued once taken.
// Maps decoded memory responses back to the I$ return format.

`default_nettype none

module icache_miss_adapter (
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  input  wire logic                          miss_valid_i,
  output logic                               miss_ready_o,
  input  wire adapter_mem_pkg::icache_miss_t miss_i,
  output logic                               req_valid_o,
  input  wire logic                          req_ready_i,
  output adapter_mem_pkg::mem_req_t          req_o,
  input  wire logic                          resp_valid_i,
  input  wire adapter_mem_pkg::mem_resp_t    resp_i,
  output logic                               rtrn_valid_o,
  output l15_pkg::icache_rtrn_t              rtrn_o
);

  adapter_mem_pkg::mem_req_t miss_req;

  // Non-cached fills fetch one word, cached fills a whole line
  always_comb begin
    miss_req.addr      = miss_i.paddr;
    miss_req.size      = miss_i.nc ?
                         adapter_mem_pkg::mem_size_t'(adapter_mem_pkg::ICACHE_WORD_SIZE) :
                         adapter_mem_pkg::mem_size_t'(adapter_mem_pkg::ICACHE_LINE_SIZE);
    miss_req.id        = miss_i.tid;
    miss_req.cmd       = adapter_mem_pkg::READ;
    miss_req.cacheable = ~miss_i.nc;
  end

  req_slot #(
    .payload_t (adapter_mem_pkg::mem_req_t)
  ) miss_slot_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .w_i      (miss_valid_i),
    .wok_o    (miss_ready_o),
    .wdata_i  (miss_req),
    .r_i      (req_ready_i),
    .rok_o    (req_valid_o),
    .rdata_o  (req_o)
  );

  // Return formatting
  assign rtrn_valid_o     = resp_valid_i;
  assign rtrn_o.is_inv    = resp_i.inv;
  assign rtrn_o.data      = resp_i.data;
  assign rtrn_o.inv_index = resp_i.inv_idx;
  assign rtrn_o.tid       = resp_i.id;

endmodule

`default_nettype wire

// ==== verilog/l15_req_arbiter.sv ====
// L1.5 request arbiter
// Round-robin selection among the source request ports. A port takes
// part only when both its request and its data are valid, and the
// single ready goes back to the granted port alone.

`default_nettype none

module l15_req_arbiter #(
  parameter int N = 3
) (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic [N-1:0]                valid_i,
  input  wire logic [N-1:0]                data_valid_i,
  output logic [N-1:0]                     ready_o,
  input  wire adapter_mem_pkg::mem_req_t   req_i [N],
  input  wire adapter_mem_pkg::mem_wdata_t data_i [N],
  output logic                             valid_o,
  input  wire logic                        ready_i,
  output adapter_mem_pkg::mem_req_t        req_o,
  output adapter_mem_pkg::mem_wdata_t      data_o,
  output adapter_mem_pkg::port_id_t        pid_o
);

  logic [N-1:0]              eligible;
  logic                      found;
  adapter_mem_pkg::port_id_t grant;
  adapter_mem_pkg::port_id_t last_q;

  assign eligible = valid_i & data_valid_i;

  // Search starts one past the last served port
  always_comb begin
    int idx;
    found = 1'b0;
    grant = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(last_q) + 1 + k) % N;
      if (!found && eligible[idx]) begin
        found = 1'b1;
        grant = adapter_mem_pkg::port_id_t'(idx);
      end
    end
  end

  always_comb begin
    ready_o = '0;
    if (found) begin
      ready_o[grant] = ready_i;
    end
  end

  assign valid_o = found;
  assign req_o   = req_i[grant];
  assign data_o  = data_i[grant];
  assign pid_o   = grant;

  // Port 0 wins first after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= adapter_mem_pkg::port_id_t'(N - 1);
    end else if (valid_o && ready_i) begin
      last_q <= grant;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/l15_bridge.sv ====
// L1.5 bridge
// Encodes the granted memory request into an L1.5 request held until
// the header acknowledge. Remembers the issuing port of each id and
// decodes L1.5 returns into tagged memory responses.

`default_nettype none

module l15_bridge (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        valid_i,
  output logic                             ready_o,
  input  wire adapter_mem_pkg::mem_req_t   req_i,
  input  wire adapter_mem_pkg::mem_wdata_t data_i,
  input  wire adapter_mem_pkg::port_id_t   pid_i,
  output l15_pkg::l15_req_t                l15_req_o,
  input  wire l15_pkg::l15_rtrn_t          l15_rtrn_i,
  output logic                             resp_valid_o,
  output adapter_mem_pkg::mem_resp_t       resp_o,
  output adapter_mem_pkg::port_id_t        resp_pid_o
);

  localparam int ID_CNT = 2 ** $bits(adapter_mem_pkg::mem_id_t);

  l15_pkg::l15_req_t         req_enc;
  l15_pkg::l15_req_t         req_held;
  logic                      held;
  logic                      rtrn_inv;
  adapter_mem_pkg::port_id_t pid_table [ID_CNT];

  // Request encoding
  always_comb begin
    req_enc.val = 1'b1;
    if (pid_i == adapter_mem_pkg::port_id_t'(0)) begin
      req_enc.rqtype = l15_pkg::IFILL;
    end else if (req_i.cmd == adapter_mem_pkg::WRITE) begin
      req_enc.rqtype = l15_pkg::STORE;
    end else begin
      req_enc.rqtype = l15_pkg::LOAD;
    end
    req_enc.nc       = ~req_i.cacheable;
    req_enc.size     = req_i.size;
    req_enc.threadid = req_i.id;
    req_enc.address  = req_i.addr;
    req_enc.data     = data_i;
  end

  // Held until the L1.5 takes the header
  req_slot #(
    .payload_t (l15_pkg::l15_req_t)
  ) l15_slot_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .w_i      (valid_i),
    .wok_o    (ready_o),
    .wdata_i  (req_enc),
    .r_i      (l15_rtrn_i.header_ack),
    .rok_o    (held),
    .rdata_o  (req_held)
  );

  always_comb begin
    l15_req_o     = req_held;
    l15_req_o.val = held;
  end

  // Source port per transaction id
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      pid_table[req_i.id] <= pid_i;
    end
  end

  // Return decoding, invalidations always go to the I$
  assign rtrn_inv     = (l15_rtrn_i.rtype == l15_pkg::INV);
  assign resp_valid_o = l15_rtrn_i.val;
  assign resp_pid_o   = rtrn_inv ? adapter_mem_pkg::port_id_t'(0) :
                                   pid_table[l15_rtrn_i.threadid];

  always_comb begin
    resp_o.data    = l15_rtrn_i.data;
    resp_o.id      = l15_rtrn_i.threadid;
    // L1.5 returns carry no error
    resp_o.error   = 1'b0;
    resp_o.inv     = rtrn_inv;
    resp_o.inv_idx = l15_rtrn_i.inv_index;
  end

endmodule

`default_nettype wire

// ==== verilog/l15_resp_demux.sv ====
// L1.5 response demux
// Registers a decoded response and raises the valid strobe of the
// one source port selected by the port id.

`default_nettype none

module l15_resp_demux #(
  parameter int N = 3
) (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       valid_i,
  input  wire adapter_mem_pkg::mem_resp_t resp_i,
  input  wire adapter_mem_pkg::port_id_t  pid_i,
  output logic [N-1:0]                    valid_o,
  output adapter_mem_pkg::mem_resp_t      resp_o
);

  logic [N-1:0]               sel;
  logic [N-1:0]               valid_q;
  adapter_mem_pkg::mem_resp_t resp_q;

  always_comb begin
    sel = '0;
    for (int i = 0; i < N; i++) begin
      sel[i] = (pid_i == adapter_mem_pkg::port_id_t'(i));
    end
  end

  // One-cycle strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_i ? sel : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      resp_q <= resp_i;
    end
  end

  assign valid_o = valid_q;
  assign resp_o  = resp_q;

endmodule

`default_nettype wire

// ==== verilog/l15_adapter_top.sv ====
// L1.5 adapter top level
// Connects the instruction cache and the data cache read and uncached
// write ports to the native L1.5 request and return ports through
// formatting, arbitration, bridge and response routing stages.

`default_nettype none

module l15_adapter_top (
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,
  // Instruction cache
  input  wire logic                          icache_miss_valid_i,
  output logic                               icache_miss_ready_o,
  input  wire adapter_mem_pkg::icache_miss_t icache_miss_i,
  output logic                               icache_rtrn_valid_o,
  output l15_pkg::icache_rtrn_t              icache_rtrn_o,
  // Data cache read miss
  input  wire logic                          dcache_miss_valid_i,
  output logic                               dcache_miss_ready_o,
  input  wire adapter_mem_pkg::mem_req_t     dcache_miss_i,
  output logic                               dcache_miss_resp_valid_o,
  output adapter_mem_pkg::mem_resp_t         dcache_miss_resp_o,
  // Data cache uncached write
  input  wire logic                          dcache_uc_write_valid_i,
  input  wire logic                          dcache_uc_write_data_valid_i,
  output logic                               dcache_uc_write_ready_o,
  input  wire adapter_mem_pkg::mem_req_t     dcache_uc_write_i,
  input  wire adapter_mem_pkg::mem_wdata_t   dcache_uc_write_data_i,
  output logic                               dcache_uc_write_resp_valid_o,
  output adapter_mem_pkg::mem_resp_t         dcache_uc_write_resp_o,
  // L1.5
  output l15_pkg::l15_req_t                  l15_req_o,
  input  wire l15_pkg::l15_rtrn_t            l15_rtrn_i
);

  localparam int N = adapter_mem_pkg::PORT_CNT;

  logic [N-1:0]                arb_valid;
  logic [N-1:0]                arb_data_valid;
  logic [N-1:0]                arb_ready;
  adapter_mem_pkg::mem_req_t   arb_req [N];
  adapter_mem_pkg::mem_wdata_t arb_data [N];

  logic                        gnt_valid;
  logic                        gnt_ready;
  adapter_mem_pkg::mem_req_t   gnt_req;
  adapter_mem_pkg::mem_wdata_t gnt_data;
  adapter_mem_pkg::port_id_t   gnt_pid;

  logic                        dec_valid;
  adapter_mem_pkg::mem_resp_t  dec_resp;
  adapter_mem_pkg::port_id_t   dec_pid;

  logic [N-1:0]                rsp_valid;
  adapter_mem_pkg::mem_resp_t  rsp;

  logic                        ic_req_valid;
  adapter_mem_pkg::mem_req_t   ic_req;

  icache_miss_adapter icache_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .miss_valid_i (icache_miss_valid_i),
    .miss_ready_o (icache_miss_ready_o),
    .miss_i       (icache_miss_i),
    .req_valid_o  (ic_req_valid),
    .req_ready_i  (arb_ready[0]),
    .req_o        (ic_req),
    .resp_valid_i (rsp_valid[0]),
    .resp_i       (rsp),
    .rtrn_valid_o (icache_rtrn_valid_o),
    .rtrn_o       (icache_rtrn_o)
  );

  // Port 0, instruction fills carry no data
  assign arb_valid[0]      = ic_req_valid;
  assign arb_data_valid[0] = 1'b1;
  assign arb_req[0]        = ic_req;
  assign arb_data[0]       = '0;

  // Port 1, data read misses
  assign arb_valid[1]        = dcache_miss_valid_i;
  assign arb_data_valid[1]   = 1'b1;
  assign arb_req[1]          = dcache_miss_i;
  assign arb_data[1]         = '0;
  assign dcache_miss_ready_o = arb_ready[1];

  // Port 2, one ready serves request and data
  assign arb_valid[2]            = dcache_uc_write_valid_i;
  assign arb_data_valid[2]       = dcache_uc_write_data_valid_i;
  assign arb_req[2]              = dcache_uc_write_i;
  assign arb_data[2]             = dcache_uc_write_data_i;
  assign dcache_uc_write_ready_o = arb_ready[2];

  l15_req_arbiter #(
    .N (N)
  ) arbiter_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (arb_valid),
    .data_valid_i (arb_data_valid),
    .ready_o      (arb_ready),
    .req_i        (arb_req),
    .data_i       (arb_data),
    .valid_o      (gnt_valid),
    .ready_i      (gnt_ready),
    .req_o        (gnt_req),
    .data_o       (gnt_data),
    .pid_o        (gnt_pid)
  );

  l15_bridge bridge_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (gnt_valid),
    .ready_o      (gnt_ready),
    .req_i        (gnt_req),
    .data_i       (gnt_data),
    .pid_i        (gnt_pid),
    .l15_req_o    (l15_req_o),
    .l15_rtrn_i   (l15_rtrn_i),
    .resp_valid_o (dec_valid),
    .resp_o       (dec_resp),
    .resp_pid_o   (dec_pid)
  );

  l15_resp_demux #(
    .N (N)
  ) demux_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (dec_valid),
    .resp_i   (dec_resp),
    .pid_i    (dec_pid),
    .valid_o  (rsp_valid),
    .resp_o   (rsp)
  );

  // D$ reads see one 64-bit word
  assign dcache_miss_resp_valid_o = rsp_valid[1];
  always_comb begin
    dcache_miss_resp_o      = rsp;
    dcache_miss_resp_o.data = {64'b0, rsp.data[63:0]};
  end

  // Store acks have no data
  assign dcache_uc_write_resp_valid_o = rsp_valid[2];
  always_comb begin
    dcache_uc_write_resp_o      = rsp;
    dcache_uc_write_resp_o.data = '0;
  end

endmodule

`default_nettype wire

// ==== verif/tb_l15_adapter.sv ====
// L1.5 adapter testbench
// Applies a table of I$ fills, D$ read misses, uncached writes and
// invalidations to the adapter, plays the L1.5 side with a random
// header acknowledge delay and checks requests and routed responses.

`default_nettype none

module tb_l15_adapter;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD     = 100;
  localparam int VEC_CNT        = 9;
  localparam int CYCLES_PER_VEC = 30;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Source 0 is the I$, 1 the D$ read, 2 the uncached write, 3 an INV only
  typedef struct packed {
    logic [1:0]           src;
    logic                 burst;
    logic                 late;
    logic [39:0]          addr;
    logic                 nc;
    logic [2:0]           size;
    logic [1:0]           id;
    logic [63:0]          wdata;
    l15_pkg::l15_rqtype_e exp_rqtype;
    logic                 exp_nc;
    logic [2:0]           exp_size;
    l15_pkg::l15_rtype_e  rtype;
    logic [127:0]         rdata;
    logic [7:0]           inv_index;
  } vec_t;

  logic                          clk_i;
  logic                          arst_n_i;
  logic [2:0]                    src_valid;
  logic [2:0]                    src_ready;
  logic                          icache_miss_ready_o;
  adapter_mem_pkg::icache_miss_t icache_miss_i;
  logic                          icache_rtrn_valid_o;
  l15_pkg::icache_rtrn_t         icache_rtrn_o;
  logic                          dcache_miss_ready_o;
  adapter_mem_pkg::mem_req_t     dcache_miss_i;
  logic                          dcache_miss_resp_valid_o;
  adapter_mem_pkg::mem_resp_t    dcache_miss_resp_o;
  logic                          dcache_uc_write_data_valid_i;
  logic                          dcache_uc_write_ready_o;
  adapter_mem_pkg::mem_req_t     dcache_uc_write_i;
  adapter_mem_pkg::mem_wdata_t   dcache_uc_write_data_i;
  logic                          dcache_uc_write_resp_valid_o;
  adapter_mem_pkg::mem_resp_t    dcache_uc_write_resp_o;
  l15_pkg::l15_req_t             l15_req_o;
  l15_pkg::l15_rtrn_t            l15_rtrn_i;

  vec_t        vecs [VEC_CNT];
  int          issue_n [3];
  int          taken_n [3];
  logic [31:0] lfsr_q;

  l15_adapter_top dut_i (
    .clk_i                        (clk_i),
    .arst_n_i                     (arst_n_i),
    .icache_miss_valid_i          (src_valid[0]),
    .icache_miss_ready_o          (icache_miss_ready_o),
    .icache_miss_i                (icache_miss_i),
    .icache_rtrn_valid_o          (icache_rtrn_valid_o),
    .icache_rtrn_o                (icache_rtrn_o),
    .dcache_miss_valid_i          (src_valid[1]),
    .dcache_miss_ready_o          (dcache_miss_ready_o),
    .dcache_miss_i                (dcache_miss_i),
    .dcache_miss_resp_valid_o     (dcache_miss_resp_valid_o),
    .dcache_miss_resp_o           (dcache_miss_resp_o),
    .dcache_uc_write_valid_i      (src_valid[2]),
    .dcache_uc_write_data_valid_i (dcache_uc_write_data_valid_i),
    .dcache_uc_write_ready_o      (dcache_uc_write_ready_o),
    .dcache_uc_write_i            (dcache_uc_write_i),
    .dcache_uc_write_data_i       (dcache_uc_write_data_i),
    .dcache_uc_write_resp_valid_o (dcache_uc_write_resp_valid_o),
    .dcache_uc_write_resp_o       (dcache_uc_write_resp_o),
    .l15_req_o                    (l15_req_o),
    .l15_rtrn_i                   (l15_rtrn_i)
  );

  assign src_ready = {dcache_uc_write_ready_o, dcache_miss_ready_o, icache_miss_ready_o};

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Raises a source valid for each issued request, drops it once taken
  initial begin
    src_valid = '0;
    for (int s = 0; s < 3; s++) begin
      taken_n[s] = 0;
    end
    forever begin
      @(posedge clk_i);
      for (int s = 0; s < 3; s++) begin
        if (src_valid[s]) begin
          if (src_ready[s]) begin
            src_valid[s] <= 1'b0;
            taken_n[s]   <= taken_n[s] + 1;
          end
        end else if (issue_n[s] != taken_n[s]) begin
          src_valid[s] <= 1'b1;
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * CYCLES_PER_VEC * (VEC_CNT + 4));
    $display("Timeout: the adapter stopped making progress");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  task automatic compare(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s: got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // First pending port after the last served one
  function automatic int next_port(input int last, input logic [2:0] pending);
    int p;
    int pick;
    pick = -1;
    for (int k = 1; k <= 3; k++) begin
      p = (last + k) % 3;
      if (pending[p] && pick < 0) begin
        pick = p;
      end
    end
    return pick;
  endfunction

  task automatic load_table();
    // src, burst, late, addr, nc, size, id, wdata,
    // exp rqtype, exp nc, exp size, return type, return data, inv index
    vecs[0] = '{2'd0, 1'b0, 1'b0, 40'h00_1000_0040, 1'b0, 3'd0, 2'd0, 64'h0,
                l15_pkg::IFILL, 1'b0, 3'd4, l15_pkg::IFILL_RET,
                128'h0f0e0d0c_0b0a0908_07060504_03020100, 8'h00};
    vecs[1] = '{2'd0, 1'b0, 1'b0, 40'h80_0000_0108, 1'b1, 3'd0, 2'd1, 64'h0,
                l15_pkg::IFILL, 1'b1, 3'd3, l15_pkg::IFILL_RET,
                128'h11112222_33334444_55556666_77778888, 8'h00};
    vecs[2] = '{2'd1, 1'b0, 1'b0, 40'h00_2000_0a08, 1'b0, 3'd3, 2'd2, 64'h0,
                l15_pkg::LOAD, 1'b0, 3'd3, l15_pkg::LOAD_RET,
                128'hdeadbeef_00c0ffee_12345678_9abcdef0, 8'h00};
    vecs[3] = '{2'd2, 1'b0, 1'b1, 40'h80_0000_2010, 1'b1, 3'd2, 2'd3,
                64'h0000_0000_cafe_f00d, l15_pkg::STORE, 1'b1, 3'd2,
                l15_pkg::ST_ACK, 128'h0, 8'h00};
    // INV on an id whose table entry points at the D$ read port
    vecs[4] = '{2'd3, 1'b0, 1'b0, 40'h0, 1'b0, 3'd0, 2'd2, 64'h0,
                l15_pkg::LOAD, 1'b0, 3'd0, l15_pkg::INV, 128'h0, 8'h5a};
    // Burst, the first request is held while the others queue up
    vecs[5] = '{2'd1, 1'b1, 1'b0, 40'h00_3000_0000, 1'b0, 3'd3, 2'd0, 64'h0,
                l15_pkg::LOAD, 1'b0, 3'd3, l15_pkg::LOAD_RET,
                128'haaaa5555_aaaa5555_0badf00d_76543210, 8'h00};
    vecs[6] = '{2'd0, 1'b1, 1'b0, 40'h00_4000_0080, 1'b0, 3'd0, 2'd1, 64'h0,
                l15_pkg::IFILL, 1'b0, 3'd4, l15_pkg::IFILL_RET,
                128'h01234567_89abcdef_fedcba98_76543210, 8'h00};
    vecs[7] = '{2'd1, 1'b1, 1'b0, 40'h00_5000_0010, 1'b0, 3'd2, 2'd2, 64'h0,
                l15_pkg::LOAD, 1'b0, 3'd2, l15_pkg::LOAD_RET,
                128'hffff0000_ffff0000_13579bdf_2468ace0, 8'h00};
    vecs[8] = '{2'd2, 1'b1, 1'b0, 40'h80_0000_3018, 1'b1, 3'd3, 2'd3,
                64'h8765_4321_0fed_cba9, l15_pkg::STORE, 1'b1, 3'd3,
                l15_pkg::ST_ACK, 128'h0, 8'h00};
  endtask

  // Puts a request on its source port, called on a rising edge
  task automatic issue(input int i);
    case (vecs[i].src)
      2'd0: begin
        icache_miss_i.paddr <= vecs[i].addr;
        icache_miss_i.nc    <= vecs[i].nc;
        icache_miss_i.tid   <= vecs[i].id;
      end
      2'd1: begin
        dcache_miss_i.addr      <= vecs[i].addr;
        dcache_miss_i.size      <= vecs[i].size;
        dcache_miss_i.id        <= vecs[i].id;
        dcache_miss_i.cmd       <= adapter_mem_pkg::READ;
        dcache_miss_i.cacheable <= ~vecs[i].nc;
      end
      default: begin
        dcache_uc_write_i.addr       <= vecs[i].addr;
        dcache_uc_write_i.size       <= vecs[i].size;
        dcache_uc_write_i.id         <= vecs[i].id;
        dcache_uc_write_i.cmd        <= adapter_mem_pkg::WRITE;
        dcache_uc_write_i.cacheable  <= ~vecs[i].nc;
        dcache_uc_write_data_i       <= vecs[i].wdata;
        dcache_uc_write_data_valid_i <= ~vecs[i].late;
      end
    endcase
    issue_n[vecs[i].src] <= issue_n[vecs[i].src] + 1;
  endtask

  // L1.5 side, checks the request and acknowledges after a random delay
  task automatic serve_request(input int i);
    l15_pkg::l15_req_t snap;
    int                delay;
    @(negedge clk_i);
    while (!l15_req_o.val) begin
      @(negedge clk_i);
    end
    snap = l15_req_o;
    compare("l15_req_o.rqtype", l15_req_o.rqtype, vecs[i].exp_rqtype);
    compare("l15_req_o.nc", l15_req_o.nc, vecs[i].exp_nc);
    compare("l15_req_o.size", l15_req_o.size, vecs[i].exp_size);
    compare("l15_req_o.threadid", l15_req_o.threadid, vecs[i].id);
    compare("l15_req_o.address", l15_req_o.address, vecs[i].addr);
    compare("l15_req_o.data", l15_req_o.data, vecs[i].wdata);
    delay = draw_bits(2);
    repeat (delay) begin
      @(negedge clk_i);
      compare("l15_req_o", l15_req_o, snap);
    end
    @(posedge clk_i);
    l15_rtrn_i.header_ack <= 1'b1;
  endtask

  // Sends the return and checks the one response strobe it causes
  task automatic serve_return(input int i);
    int port;
    port = (vecs[i].src == 2'd3) ? 0 : int'(vecs[i].src);
    @(posedge clk_i);
    l15_rtrn_i.header_ack <= 1'b0;
    l15_rtrn_i.val        <= 1'b1;
    l15_rtrn_i.rtype      <= vecs[i].rtype;
    l15_rtrn_i.threadid   <= vecs[i].id;
    l15_rtrn_i.data       <= vecs[i].rdata;
    l15_rtrn_i.inv_index  <= vecs[i].inv_index;
    @(posedge clk_i);
    l15_rtrn_i.val <= 1'b0;
    @(negedge clk_i);
    compare("resp valids {uc_write,miss,icache}",
            {dcache_uc_write_resp_valid_o, dcache_miss_resp_valid_o, icache_rtrn_valid_o},
            3'b001 << port);
    case (vecs[i].src)
      2'd0: begin
        compare("icache_rtrn_o.is_inv", icache_rtrn_o.is_inv, 1'b0);
        compare("icache_rtrn_o.data", icache_rtrn_o.data, vecs[i].rdata);
        compare("icache_rtrn_o.tid", icache_rtrn_o.tid, vecs[i].id);
      end
      2'd1: begin
        compare("dcache_miss_resp_o.data", dcache_miss_resp_o.data,
                {64'b0, vecs[i].rdata[63:0]});
        compare("dcache_miss_resp_o.id", dcache_miss_resp_o.id, vecs[i].id);
      end
      2'd2: begin
        compare("dcache_uc_write_resp_o.id", dcache_uc_write_resp_o.id, vecs[i].id);
      end
      default: begin
        compare("icache_rtrn_o.is_inv", icache_rtrn_o.is_inv, 1'b1);
        compare("icache_rtrn_o.inv_index", icache_rtrn_o.inv_index, vecs[i].inv_index);
      end
    endcase
    @(negedge clk_i);
    compare("resp valids {uc_write,miss,icache}",
            {dcache_uc_write_resp_valid_o, dcache_miss_resp_valid_o, icache_rtrn_valid_o},
            3'b000);
  endtask

  task automatic run_single(input int i);
    if (vecs[i].src != 2'd3) begin
      @(posedge clk_i);
      issue(i);
      if (vecs[i].late) begin
        // Write data still missing, nothing may be taken
        repeat (3) begin
          @(negedge clk_i);
          compare("dcache_uc_write_ready_o", dcache_uc_write_ready_o, 1'b0);
          compare("l15_req_o.val", l15_req_o.val, 1'b0);
        end
        @(posedge clk_i);
        dcache_uc_write_data_valid_i <= 1'b1;
      end
      serve_request(i);
    end
    serve_return(i);
  endtask

  task automatic run_burst(input int first, input int stop);
    l15_pkg::l15_req_t snap;
    logic [2:0]        pending;
    int                last;
    int                port;
    @(posedge clk_i);
    issue(first);
    @(negedge clk_i);
    while (!l15_req_o.val) begin
      @(negedge clk_i);
    end
    snap = l15_req_o;
    pending = '0;
    @(posedge clk_i);
    for (int k = first + 1; k < stop; k++) begin
      issue(k);
      pending[vecs[k].src] = 1'b1;
    end
    // No header ack yet, so the request holds and data ports wait
    repeat (3) begin
      @(negedge clk_i);
      compare("l15_req_o", l15_req_o, snap);
      compare("dcache_miss_ready_o", dcache_miss_ready_o, 1'b0);
      compare("dcache_uc_write_ready_o", dcache_uc_write_ready_o, 1'b0);
    end
    serve_request(first);
    serve_return(first);
    last = int'(vecs[first].src);
    while (pending != '0) begin
      port = next_port(last, pending);
      for (int k = first + 1; k < stop; k++) begin
        if (int'(vecs[k].src) == port) begin
          serve_request(k);
          serve_return(k);
        end
      end
      pending[port] = 1'b0;
      last = port;
    end
  endtask

  initial begin
    int i;
    int j;
    arst_n_i                     = 1'b0;
    icache_miss_i                = '0;
    dcache_miss_i                = '0;
    dcache_uc_write_i            = '0;
    dcache_uc_write_data_i       = '0;
    dcache_uc_write_data_valid_i = 1'b0;
    l15_rtrn_i                   = '0;
    lfsr_q                       = 32'hd02c;
    for (int s = 0; s < 3; s++) begin
      issue_n[s] = 0;
    end
    load_table();
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    @(negedge clk_i);
    compare("icache_rtrn_valid_o", icache_rtrn_valid_o, 1'b0);
    compare("dcache_miss_resp_valid_o", dcache_miss_resp_valid_o, 1'b0);
    compare("dcache_uc_write_resp_valid_o", dcache_uc_write_resp_valid_o, 1'b0);
    compare("l15_req_o.val", l15_req_o.val, 1'b0);
    compare("icache_miss_ready_o", icache_miss_ready_o, 1'b1);

    i = 0;
    while (i < VEC_CNT) begin
      if (vecs[i].burst) begin
        j = i + 1;
        while (j < VEC_CNT && vecs[j].burst) begin
          j++;
        end
        run_burst(i, j);
        i = j;
      end else begin
        run_single(i);
        i++;
      end
    end

    repeat (2) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/adapter_mem_pkg.sv
verilog/l15_pkg.sv
verilog/req_slot.sv
verilog/icache_miss_adapter.sv
verilog/l15_req_arbiter.sv
verilog/l15_bridge.sv
verilog/l15_resp_demux.sv
verilog/l15_adapter_top.sv
verif/tb_l15_adapter.sv
